/* logic/stream_pack_pkg.sv */
/* Widths, keep codes and the data word views shared by the stream packer.
 * Every RTL module and the testbench import it.
 */

`default_nettype none

package stream_pack_pkg;

    // ****************************************
    // Stream geometry
    // ****************************************

    localparam int tdata_bytes = 4;     // Bytes per beat.
    localparam int half_bytes = 2;      // Bytes in one half beat.

    localparam int tdest_width = 4;     // Routing field.
    localparam int tuser_width = 4;     // User sideband.
    localparam int tid_width = 4;       // Stream identifier.

    // Malformed beat counter. Saturates at all ones.
    localparam int count_width = 16;

    // ****************************************
    // Legal keep codes
    // ****************************************

    // A full beat has every byte kept.
    localparam logic [tdata_bytes-1:0] keep_full = 4'b1111;

    // A low-half beat keeps bytes 0 to 1 only.
    // Bytes 2 to 3 are idle.
    localparam logic [tdata_bytes-1:0] keep_low = 4'b0011;

    // Anything else, 0000 included, is malformed and gets dropped.

    // ****************************************
    // Data word views
    // ****************************************

    // The same 32 bits seen two ways.
    // The ports and the stage move the whole word.
    // The join builds packed beats one half at a time.
    // half[0] is bytes 0 to 1, half[1] is bytes 2 to 3.
    typedef union packed {
        logic [8*tdata_bytes-1:0] word;             // Whole beat.
        logic [1:0][8*half_bytes-1:0] half;         // Low and high halves.
    } beat_data_u;

endpackage

`default_nettype wire

/* logic/stream_beat_stage.sv */
/* One-deep input register slice for the packer. It accepts an rx beat,
 * holds it for the join and tells the classifier when a beat was loaded.
 */

`timescale 1ns/1ps
`default_nettype none

module stream_beat_stage (
    input wire aclk,
    input wire areset_n,
    // Input stream.
    input wire rx_tvalid,
    output logic rx_tready,
    input wire stream_pack_pkg::beat_data_u rx_tdata,
    input wire rx_tlast,
    input wire [stream_pack_pkg::tuser_width-1:0] rx_tuser,
    input wire [stream_pack_pkg::tdest_width-1:0] rx_tdest,
    input wire [stream_pack_pkg::tid_width-1:0] rx_tid,
    // Join side.
    input wire join_ready,
    output logic load,
    output logic stage_valid,
    output stream_pack_pkg::beat_data_u stage_data,
    output logic stage_last,
    output logic [stream_pack_pkg::tuser_width-1:0] stage_user,
    output logic [stream_pack_pkg::tdest_width-1:0] stage_dest,
    output logic [stream_pack_pkg::tid_width-1:0] stage_id
);
    // ****************************************
    // Handshake
    // ****************************************

    // Room when empty, or when the join takes the current beat this cycle.
    always_comb rx_tready = !stage_valid || join_ready;

    // A transfer on rx. The classifier samples keep on the same strobe.
    always_comb load = rx_tvalid && rx_tready;

    // ****************************************
    // Beat register
    // ****************************************

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            stage_valid <= 1'b0;                // Empty after reset.
        end
        else if (load) begin
            stage_valid <= 1'b1;                // New beat replaces the old one.
        end
        else if (join_ready) begin
            stage_valid <= 1'b0;                // Consumed with nothing behind it.
        end
    end

    // Payload follows the load strobe only.
    always_ff @(posedge aclk) begin
        if (load) begin
            stage_data <= rx_tdata;
            stage_last <= rx_tlast;
            stage_user <= rx_tuser;
            stage_dest <= rx_tdest;
            stage_id <= rx_tid;
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    // While the join stalls, the held beat must not move.
    // This depends on the join keeping join_ready low through a flush
    // and through output back-pressure.
    stage_hold_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (stage_valid && !join_ready) |=>
            (stage_valid && $stable(stage_data) && $stable(stage_last) &&
             $stable(stage_user) && $stable(stage_dest) && $stable(stage_id))
    ) else $error("Stage beat changed while the join was stalled.");

endmodule

`default_nettype wire

/* logic/stream_keep_classify.sv */
/* Keep classifier running beside the input stage. It flags the halves of
 * each loaded beat for the join and counts malformed keep codes.
 */

`timescale 1ns/1ps
`default_nettype none

module stream_keep_classify (
    input wire aclk,
    input wire areset_n,
    input wire load,                                    // rx transfer strobe.
    input wire [stream_pack_pkg::tdata_bytes-1:0] rx_tkeep,
    output logic half_low_full,
    output logic half_high_valid,
    output logic [stream_pack_pkg::count_width-1:0] malformed_count
);
    import stream_pack_pkg::*;

    logic [half_bytes-1:0] keep_lo;     // Bytes 0 to 1.
    logic [half_bytes-1:0] keep_hi;     // Bytes 2 to 3.
    logic malformed;

    always_comb keep_lo = rx_tkeep[0 +: half_bytes];
    always_comb keep_hi = rx_tkeep[half_bytes +: half_bytes];

    // Neither of the two legal codes.
    always_comb malformed = (rx_tkeep != keep_full) && (rx_tkeep != keep_low);

    // ****************************************
    // Half flags
    // ****************************************

    // The low half only counts as full when the high half is uniform.
    // A partly kept high half spoils the whole beat.
    // The join then reads low_full with high_valid as a full beat,
    // low_full alone as a low-half beat, and no low_full as malformed.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            half_low_full <= 1'b0;
            half_high_valid <= 1'b0;
        end
        else if (load) begin
            half_low_full <= (&keep_lo) && ((&keep_hi) || !(|keep_hi));
            half_high_valid <= &keep_hi;
        end
    end

    // ****************************************
    // Malformed counter
    // ****************************************

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            malformed_count <= '0;
        end
        else if (load && malformed && !(&malformed_count)) begin
            malformed_count <= malformed_count + 1'b1;      // Stops at all ones.
        end
    end

    // Monotonic outside reset, including at saturation.
    count_monotonic: assert property (
        @(posedge aclk) disable iff (!areset_n)
        malformed_count >= $past(malformed_count)
    ) else $error("Malformed counter went backwards.");

endmodule

`default_nettype wire

/* logic/stream_pack_join.sv */
/* Join FSM and output register of the packer. Pairs of low-half beats
 * become full beats, full beats pass through and malformed beats vanish.
 */

`timescale 1ns/1ps
`default_nettype none

module stream_pack_join (
    input wire aclk,
    input wire areset_n,
    // Stage side.
    input wire stage_valid,
    output logic join_ready,
    input wire stream_pack_pkg::beat_data_u stage_data,
    input wire stage_last,
    input wire [stream_pack_pkg::tuser_width-1:0] stage_user,
    input wire [stream_pack_pkg::tdest_width-1:0] stage_dest,
    input wire [stream_pack_pkg::tid_width-1:0] stage_id,
    // Class flags, aligned with the stage beat.
    input wire half_low_full,
    input wire half_high_valid,
    // Output stream.
    output logic tx_tvalid,
    input wire tx_tready,
    output stream_pack_pkg::beat_data_u tx_tdata,
    output logic [stream_pack_pkg::tdata_bytes-1:0] tx_tkeep,
    output logic tx_tlast,
    output logic [stream_pack_pkg::tuser_width-1:0] tx_tuser,
    output logic [stream_pack_pkg::tdest_width-1:0] tx_tdest,
    output logic [stream_pack_pkg::tid_width-1:0] tx_tid
);
    import stream_pack_pkg::*;

    enum logic {
        join_idle,          // Nothing held.
        join_pack           // One low half waiting for its partner.
    } state;

    // Held half and the sidebands that go with it.
    logic [8*half_bytes-1:0] hold_data;
    logic [tuser_width-1:0] hold_user;
    logic [tdest_width-1:0] hold_dest;
    logic [tid_width-1:0] hold_id;

    logic beat_full;        // Stage beat has keep 1111.
    logic beat_low;         // Stage beat has keep 0011.
    logic out_free;         // Output register can take a new beat.
    logic flush;            // Held half leaves ahead of a full beat.
    logic take;             // Stage beat consumed this cycle.
    logic emit;             // Output register loads a beat.

    // ****************************************
    // Control
    // ****************************************

    always_comb beat_full = half_low_full && half_high_valid;
    always_comb beat_low = half_low_full && !half_high_valid;

    always_comb out_free = !tx_tvalid || tx_tready;

    // A full beat behind a held half waits one slot in the stage.
    always_comb flush = stage_valid && (state == join_pack) && beat_full && out_free;

    always_comb begin
        join_ready = out_free;
        if ((state == join_pack) && beat_full) begin
            join_ready = 1'b0;                  // Slot goes to the flush.
        end
    end

    always_comb take = stage_valid && join_ready;

    // Malformed beats are taken but never emitted.
    // A low half in idle without last is only held.
    always_comb begin
        emit = flush;
        if (take) begin
            if (beat_full) begin
                emit = 1'b1;
            end
            else if (beat_low) begin
                emit = (state == join_pack) || stage_last;
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= join_idle;
        end
        else if (flush) begin
            state <= join_idle;
        end
        else if (take && beat_low) begin
            if ((state == join_idle) && !stage_last) begin
                state <= join_pack;             // Wait for the partner.
            end
            else begin
                state <= join_idle;             // Joined, or passed with last.
            end
        end
    end

    // Capture in idle. Harmless when the beat passes straight out.
    always_ff @(posedge aclk) begin
        if (take && beat_low && (state == join_idle)) begin
            hold_data <= stage_data.half[0];
            hold_user <= stage_user;
            hold_dest <= stage_dest;
            hold_id <= stage_id;
        end
    end

    // ****************************************
    // Output register
    // ****************************************

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_tvalid <= 1'b0;
        end
        else if (out_free) begin
            tx_tvalid <= emit;
        end
    end

    // Idle upper bytes of a half beat go out as zero.
    always_ff @(posedge aclk) begin
        if (out_free && emit) begin
            if (flush) begin
                tx_tdata.half[0] <= hold_data;
                tx_tdata.half[1] <= '0;
                tx_tkeep <= keep_low;
                tx_tlast <= 1'b0;               // Stream carries on with the full beat.
                tx_tuser <= hold_user;
                tx_tdest <= hold_dest;
                tx_tid <= hold_id;
            end
            else if (beat_low && (state == join_pack)) begin
                tx_tdata.half[0] <= hold_data;                  // First beat low.
                tx_tdata.half[1] <= stage_data.half[0];         // Second beat high.
                tx_tkeep <= keep_full;
                tx_tlast <= stage_last;
                tx_tuser <= hold_user;
                tx_tdest <= hold_dest;
                tx_tid <= hold_id;
            end
            else if (beat_low) begin
                tx_tdata.half[0] <= stage_data.half[0];        // Lone half with last.
                tx_tdata.half[1] <= '0;
                tx_tkeep <= keep_low;
                tx_tlast <= stage_last;
                tx_tuser <= stage_user;
                tx_tdest <= stage_dest;
                tx_tid <= stage_id;
            end
            else begin
                tx_tdata.word <= stage_data.word;              // Full beat unchanged.
                tx_tkeep <= keep_full;
                tx_tlast <= stage_last;
                tx_tuser <= stage_user;
                tx_tdest <= stage_dest;
                tx_tid <= stage_id;
            end
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    // Malformed input must never reach the output.
    tx_keep_legal: assert property (
        @(posedge aclk) disable iff (!areset_n)
        tx_tvalid |-> (tx_tkeep == keep_full) || (tx_tkeep == keep_low)
    ) else $error("Output beat carries an illegal keep.");

    tx_hold_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (tx_tvalid && !tx_tready) |=>
            (tx_tvalid && $stable(tx_tdata) && $stable(tx_tkeep) &&
             $stable(tx_tlast) && $stable(tx_tuser) && $stable(tx_tdest) &&
             $stable(tx_tid))
    ) else $error("Output beat changed under back-pressure.");

endmodule

`default_nettype wire

/* logic/stream_pack_top.sv */
/* Top level of the 4-byte stream packer. The stage and the keep
 * classifier sit side by side on rx, and the join drives tx.
 */

`timescale 1ns/1ps
`default_nettype none

module stream_pack_top (
    input wire aclk,
    input wire areset_n,
    // Input stream.
    input wire rx_tvalid,
    output logic rx_tready,
    input wire stream_pack_pkg::beat_data_u rx_tdata,
    input wire [stream_pack_pkg::tdata_bytes-1:0] rx_tkeep,
    input wire rx_tlast,
    input wire [stream_pack_pkg::tuser_width-1:0] rx_tuser,
    input wire [stream_pack_pkg::tdest_width-1:0] rx_tdest,
    input wire [stream_pack_pkg::tid_width-1:0] rx_tid,
    // Output stream.
    output logic tx_tvalid,
    input wire tx_tready,
    output stream_pack_pkg::beat_data_u tx_tdata,
    output logic [stream_pack_pkg::tdata_bytes-1:0] tx_tkeep,
    output logic tx_tlast,
    output logic [stream_pack_pkg::tuser_width-1:0] tx_tuser,
    output logic [stream_pack_pkg::tdest_width-1:0] tx_tdest,
    output logic [stream_pack_pkg::tid_width-1:0] tx_tid,
    // Status.
    output logic [stream_pack_pkg::count_width-1:0] malformed_count
);
    import stream_pack_pkg::*;

    logic load;                         // rx transfer, stage to classifier.
    logic join_ready;                   // Join takes the stage beat.
    logic stage_valid;
    beat_data_u stage_data;
    logic stage_last;
    logic [tuser_width-1:0] stage_user;
    logic [tdest_width-1:0] stage_dest;
    logic [tid_width-1:0] stage_id;
    logic half_low_full;                // Aligned with the stage beat.
    logic half_high_valid;

    // ****************************************
    // Input side
    // ****************************************

    stream_beat_stage u_stage (
        .aclk(aclk), .areset_n(areset_n),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
        .rx_tdata(rx_tdata), .rx_tlast(rx_tlast),
        .rx_tuser(rx_tuser), .rx_tdest(rx_tdest), .rx_tid(rx_tid),
        .join_ready(join_ready), .load(load),
        .stage_valid(stage_valid), .stage_data(stage_data),
        .stage_last(stage_last), .stage_user(stage_user),
        .stage_dest(stage_dest), .stage_id(stage_id)
    );

    stream_keep_classify u_classify (
        .aclk(aclk), .areset_n(areset_n),
        .load(load), .rx_tkeep(rx_tkeep),
        .half_low_full(half_low_full), .half_high_valid(half_high_valid),
        .malformed_count(malformed_count)
    );

    // ****************************************
    // Output side
    // ****************************************

    stream_pack_join u_join (
        .aclk(aclk), .areset_n(areset_n),
        .stage_valid(stage_valid), .join_ready(join_ready),
        .stage_data(stage_data), .stage_last(stage_last),
        .stage_user(stage_user), .stage_dest(stage_dest), .stage_id(stage_id),
        .half_low_full(half_low_full), .half_high_valid(half_high_valid),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready),
        .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep), .tx_tlast(tx_tlast),
        .tx_tuser(tx_tuser), .tx_tdest(tx_tdest), .tx_tid(tx_tid)
    );

endmodule

`default_nettype wire

/* dv/tb_stream_pack_top.sv */
/* Random-stimulus testbench for the stream packer. A packing model predicts
 * every tx beat and the malformed count. Run it with the file list.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_stream_pack_top;
    import stream_pack_pkg::*;

    localparam int num_beats = 2000;        // rx beats accepted in total.
    localparam int stall_limit = 200;       // Cycles without progress.
    localparam int script_len = 11;         // Scripted beats at the start.

    logic aclk;
    logic areset_n;
    logic rx_tvalid;
    logic rx_tready;
    beat_data_u rx_tdata;
    logic [tdata_bytes-1:0] rx_tkeep;
    logic rx_tlast;
    logic [tuser_width-1:0] rx_tuser;
    logic [tdest_width-1:0] rx_tdest;
    logic [tid_width-1:0] rx_tid;
    logic tx_tvalid;
    logic tx_tready;
    beat_data_u tx_tdata;
    logic [tdata_bytes-1:0] tx_tkeep;
    logic tx_tlast;
    logic [tuser_width-1:0] tx_tuser;
    logic [tdest_width-1:0] tx_tdest;
    logic [tid_width-1:0] tx_tid;
    logic [count_width-1:0] malformed_count;

    // Expected tx beats, oldest first.
    beat_data_u exp_data[$];
    logic [tdata_bytes-1:0] exp_keep[$];
    logic exp_last[$];
    logic [tuser_width-1:0] exp_user[$];
    logic [tdest_width-1:0] exp_dest[$];
    logic [tid_width-1:0] exp_id[$];

    // Model state.
    logic model_held;                       // One low half waiting.
    logic [8*half_bytes-1:0] held_data;
    logic [tuser_width-1:0] held_user;
    logic [tdest_width-1:0] held_dest;
    logic [tid_width-1:0] held_id;
    logic [count_width-1:0] model_count;
    integer seed;

    stream_pack_top UUT (
        .aclk(aclk), .areset_n(areset_n),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep), .rx_tlast(rx_tlast), .rx_tuser(rx_tuser),
        .rx_tdest(rx_tdest), .rx_tid(rx_tid),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep), .tx_tlast(tx_tlast), .tx_tuser(tx_tuser),
        .tx_tdest(tx_tdest), .tx_tid(tx_tid),
        .malformed_count(malformed_count)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;            // 8 ns period.
    end

    // ****************************************
    // Error handling and checks
    // ****************************************

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "Testbench stopped at the first error.");
    endtask

    task automatic check_beat(input beat_data_u got_data,
                              input logic [tdata_bytes-1:0] got_keep, input logic got_last,
                              input logic [tuser_width-1:0] got_user,
                              input logic [tdest_width-1:0] got_dest,
                              input logic [tid_width-1:0] got_id);
        beat_data_u want_data;
        if (exp_data.size() == 0) begin
            $display("A tx beat came out while no beat was expected.");
            stop_run();
        end
        want_data = exp_data.pop_front();
        if (got_data.word !== want_data.word) begin
            $display("Mismatch tx_tdata: got %h expected %h", got_data.word, want_data.word);
            stop_run();
        end
        if (got_keep !== exp_keep[0]) begin
            $display("Mismatch tx_tkeep: got %h expected %h", got_keep, exp_keep[0]);
            stop_run();
        end
        if (got_last !== exp_last[0]) begin
            $display("Mismatch tx_tlast: got %h expected %h", got_last, exp_last[0]);
            stop_run();
        end
        if ({got_user, got_dest, got_id} !== {exp_user[0], exp_dest[0], exp_id[0]}) begin
            $display("Mismatch tx_tuser/tx_tdest/tx_tid: got %h %h %h expected %h %h %h",
                     got_user, got_dest, got_id, exp_user[0], exp_dest[0], exp_id[0]);
            stop_run();
        end
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
        void'(exp_user.pop_front());
        void'(exp_dest.pop_front());
        void'(exp_id.pop_front());
    endtask

    task automatic check_count(input logic [count_width-1:0] got,
                               input logic [count_width-1:0] want);
        if (got !== want) begin
            $display("Mismatch malformed_count: got %h expected %h", got, want);
            stop_run();
        end
    endtask

    // ****************************************
    // Packing model
    // ****************************************

    task automatic push_beat(input beat_data_u data, input logic [tdata_bytes-1:0] keep,
                             input logic last, input logic [tuser_width-1:0] user,
                             input logic [tdest_width-1:0] dest, input logic [tid_width-1:0] id);
        exp_data.push_back(data);
        exp_keep.push_back(keep);
        exp_last.push_back(last);
        exp_user.push_back(user);
        exp_dest.push_back(dest);
        exp_id.push_back(id);
    endtask

    task automatic model_beat(input beat_data_u data, input logic [tdata_bytes-1:0] keep,
                              input logic last, input logic [tuser_width-1:0] user,
                              input logic [tdest_width-1:0] dest, input logic [tid_width-1:0] id);
        beat_data_u built;
        built.half[1] = '0;                 // Idle upper bytes of a half beat.
        if (keep == keep_full) begin
            if (model_held) begin
                built.half[0] = held_data;  // Flush first, last clear.
                push_beat(built, keep_low, 1'b0, held_user, held_dest, held_id);
                model_held = 1'b0;
            end
            push_beat(data, keep_full, last, user, dest, id);
        end
        else if (keep == keep_low) begin
            if (model_held) begin
                built.half[0] = held_data;          // Held bytes go low.
                built.half[1] = data.half[0];       // New bytes go high.
                push_beat(built, keep_full, last, held_user, held_dest, held_id);
                model_held = 1'b0;
            end
            else if (last) begin
                built.half[0] = data.half[0];
                push_beat(built, keep_low, 1'b1, user, dest, id);
            end
            else begin
                model_held = 1'b1;
                held_data = data.half[0];
                held_user = user;
                held_dest = dest;
                held_id = id;
            end
        end
        else begin
            model_count = model_count + 16'd1;      // Dropped, state untouched.
        end
    endtask

    // ****************************************
    // Stimulus
    // ****************************************

    // Scripted {keep, last}: full pair, join, lone half, flush, malformed.
    function automatic logic [4:0] scripted_beat(input int idx);
        case (idx)
            0: return {keep_full, 1'b0};
            1: return {keep_full, 1'b1};
            2: return {keep_low, 1'b0};
            3: return {keep_low, 1'b1};
            4: return {keep_low, 1'b1};
            5: return {keep_low, 1'b0};
            6: return {keep_full, 1'b0};
            7: return {4'b0000, 1'b0};
            8: return {keep_low, 1'b0};
            9: return {4'b0101, 1'b1};
            default: return {keep_low, 1'b1};
        endcase
    endfunction

    task automatic load_rx_beat(input int idx);
        logic [31:0] r;
        logic [4:0] pick;
        r = $random(seed);
        rx_tdata.word = $random(seed);
        rx_tuser = r[3:0];
        rx_tdest = r[7:4];
        rx_tid = r[11:8];
        rx_tlast = (r[13:12] == 2'b11);
        if (r[19:16] < 4'd7) begin
            rx_tkeep = keep_full;
        end
        else if (r[19:16] < 4'd14) begin
            rx_tkeep = keep_low;
        end
        else begin
            rx_tkeep = r[23:20];            // Occasional malformed code.
            if ((rx_tkeep == keep_full) || (rx_tkeep == keep_low)) begin
                rx_tkeep = 4'b0000;
            end
        end
        if (idx < script_len) begin
            pick = scripted_beat(idx);
            rx_tkeep = pick[4:1];
            rx_tlast = pick[0];
        end
        rx_tvalid = (r[31:30] != 2'b00);    // Valid three times in four.
    endtask

    // Sample both streams mid-cycle, apply them just after the edge.
    task automatic step_cycle(output logic rx_fire);
        logic tx_fire;
        beat_data_u got_data;
        logic [tdata_bytes-1:0] got_keep;
        logic got_last;
        logic [tuser_width-1:0] got_user;
        logic [tdest_width-1:0] got_dest;
        logic [tid_width-1:0] got_id;
        @(negedge aclk);
        rx_fire = rx_tvalid && rx_tready;
        tx_fire = tx_tvalid && tx_tready;
        got_data = tx_tdata;
        got_keep = tx_tkeep;
        got_last = tx_tlast;
        got_user = tx_tuser;
        got_dest = tx_tdest;
        got_id = tx_tid;
        @(posedge aclk);
        #1;
        if (rx_fire) begin
            model_beat(rx_tdata, rx_tkeep, rx_tlast, rx_tuser, rx_tdest, rx_tid);
        end
        if (tx_fire) begin
            check_beat(got_data, got_keep, got_last, got_user, got_dest, got_id);
        end
    endtask

    initial begin
        logic rx_fire;
        logic [31:0] r;
        int accepted;
        int waited;
        seed = 32'hf0af8d40;
        areset_n = 1'b0;
        rx_tvalid = 1'b0;
        rx_tdata.word = '0;
        rx_tkeep = '0;
        rx_tlast = 1'b0;
        rx_tuser = '0;
        rx_tdest = '0;
        rx_tid = '0;
        tx_tready = 1'b0;
        model_held = 1'b0;
        model_count = '0;
        repeat (16) @(posedge aclk);
        #1 areset_n = 1'b1;

        // Reset state: rx ready, tx quiet, counter clear.
        waited = 0;
        while (rx_tready !== 1'b1) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > stall_limit) begin
                $display("Timed out waiting for rx_tready after reset.");
                stop_run();
            end
        end
        if (tx_tvalid !== 1'b0) begin
            $display("Mismatch tx_tvalid: got %h expected %h", tx_tvalid, 1'b0);
            stop_run();
        end
        check_count(malformed_count, '0);

        // Main traffic with random gating on both sides.
        accepted = 0;
        waited = 0;
        load_rx_beat(0);
        while (accepted < num_beats) begin
            step_cycle(rx_fire);
            r = $random(seed);
            tx_tready = r[0] | r[1];
            if (rx_fire) begin
                accepted++;
                waited = 0;
                load_rx_beat(accepted);
            end
            else begin
                waited++;
                if (!rx_tvalid) begin
                    rx_tvalid = r[2] | r[3];        // Beat content stays as loaded.
                end
                if (waited > stall_limit) begin
                    $display("Timed out waiting for the packer to accept an rx beat.");
                    stop_run();
                end
            end
        end

        // Drain everything the model expects.
        rx_tvalid = 1'b0;
        tx_tready = 1'b1;
        waited = 0;
        while (exp_data.size() != 0) begin
            step_cycle(rx_fire);
            waited++;
            if (waited > stall_limit) begin
                $display("Timed out draining tx with %0d beats still expected.",
                         exp_data.size());
                stop_run();
            end
        end
        repeat (20) step_cycle(rx_fire);        // Any extra beat fails in check_beat.
        check_count(malformed_count, model_count);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
logic/stream_pack_pkg.sv
logic/stream_beat_stage.sv
logic/stream_keep_classify.sv
logic/stream_pack_join.sv
logic/stream_pack_top.sv
dv/tb_stream_pack_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the stream packer testbench with Verilator, run it, and check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_stream_pack_top -o sim_stream_pack

status=0
./obj_dir/sim_stream_pack > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed."
    exit 0
fi
echo "Simulation failed, simulator status $status."
exit 1
